//--- rtl/clkPkg.sv
`default_nettype none

package clkPkg;

  // Diagnostic command opcodes
  localparam int cmdOpW = 2;
  localparam logic [cmdOpW-1:0] opCtl  = 2'd0;  // Control functions, 00x
  localparam logic [cmdOpW-1:0] opLoad = 2'd1;  // Load functions, 04x
  localparam logic [cmdOpW-1:0] opRead = 2'd2;  // Diagnostic read, 10x

  // Field widths
  localparam int selW     = 3;  // Function select
  localparam int nibW     = 4;  // EBus data 32..35
  localparam int statW    = 6;  // EBus data 30..35
  localparam int burstW   = 8;
  localparam int rateDivW = 3;

  // Control function codes
  localparam logic [selW-1:0] fnStart      = 3'd1;
  localparam logic [selW-1:0] fnSingleStep = 3'd2;
  localparam logic [selW-1:0] fnHalt       = 3'd3;
  localparam logic [selW-1:0] fnBurst      = 3'd5;
  localparam logic [selW-1:0] fnClrReset   = 3'd6;
  localparam logic [selW-1:0] fnSetReset   = 3'd7;

  // Load function codes
  localparam logic [selW-1:0] ldBurstLsb = 3'd2;
  localparam logic [selW-1:0] ldBurstMsb = 3'd3;
  localparam logic [selW-1:0] ldRate     = 3'd4;
  localparam logic [selW-1:0] ldGroupDis = 3'd5;

  // Load nibble, seen as rate load or as group-disable load
  typedef union packed {
    logic [nibW-1:0] raw;
    struct packed {
      logic [1:0] spare;
      logic [1:0] rateSel;
    } rate;
    struct packed {
      logic spare;
      logic crmDis;
      logic edpDis;
      logic ctlDis;
    } dis;
  } loadNibbleT;

endpackage

`default_nettype wire

//--- rtl/diagFuncDecode.sv
`timescale 1ns/100ps
`default_nettype none

module diagFuncDecode import clkPkg::*; (
  input  logic              MBOX_CLK,
  input  logic              CLK,
  input  logic              cmdValid,
  output logic              cmdReady,
  input  logic [cmdOpW-1:0] cmdOp,
  input  logic [selW-1:0]   cmdSel,
  input  logic [nibW-1:0]   cmdData,
  output logic              rdValid,
  input  logic              rdReady,
  output logic [statW-1:0]  rdData,
  input  logic [statW-1:0]  statusWord,
  output logic              startPulse,
  output logic              stepPulse,
  output logic              haltPulse,
  output logic              burstPulse,
  output logic              loadLsb,
  output logic              loadMsb,
  output logic [nibW-1:0]   loadNibble,
  output logic [selW-1:0]   readSel,
  output logic [1:0]        rateSel,
  output logic              crmDis,
  output logic              edpDis,
  output logic              ctlDis,
  output logic              mrReset
);

  logic       accept;
  logic       isCtl;
  logic       isLoad;
  logic       readPending;
  logic       clrPulse;
  logic       setPulse;
  logic       rateLoad;
  logic       disLoad;
  loadNibbleT nibReg;

  // Hold off commands while a read answer is pending or stalled
  assign cmdReady = ~(readPending | (rdValid & ~rdReady));
  assign accept   = cmdValid & cmdReady;
  assign isCtl    = accept & (cmdOp == opCtl);
  assign isLoad   = accept & (cmdOp == opLoad);

  // One-cycle function strobes
  always_ff @(posedge MBOX_CLK or posedge CLK) begin
    if (CLK) begin
      startPulse  <= 1'b0;
      stepPulse   <= 1'b0;
      haltPulse   <= 1'b0;
      burstPulse  <= 1'b0;
      clrPulse    <= 1'b0;
      setPulse    <= 1'b0;
      loadLsb     <= 1'b0;
      loadMsb     <= 1'b0;
      rateLoad    <= 1'b0;
      disLoad     <= 1'b0;
      readPending <= 1'b0;
    end else begin
      startPulse  <= isCtl & (cmdSel == fnStart);
      stepPulse   <= isCtl & (cmdSel == fnSingleStep);
      haltPulse   <= isCtl & (cmdSel == fnHalt);
      burstPulse  <= isCtl & (cmdSel == fnBurst);
      clrPulse    <= isCtl & (cmdSel == fnClrReset);
      setPulse    <= isCtl & (cmdSel == fnSetReset);
      loadLsb     <= isLoad & (cmdSel == ldBurstLsb);
      loadMsb     <= isLoad & (cmdSel == ldBurstMsb);
      rateLoad    <= isLoad & (cmdSel == ldRate);
      disLoad     <= isLoad & (cmdSel == ldGroupDis);
      readPending <= accept & (cmdOp == opRead);
    end
  end

  // Data nibble and read select ride along with the strobes
  always_ff @(posedge MBOX_CLK) begin
    if (accept) begin
      nibReg.raw <= cmdData;
      readSel    <= cmdSel;
    end
  end

  assign loadNibble = nibReg.raw;

  // Configuration and master reset, one cycle after the strobe
  always_ff @(posedge MBOX_CLK or posedge CLK) begin
    if (CLK) begin
      rateSel <= 2'd0;
      crmDis  <= 1'b0;
      edpDis  <= 1'b0;
      ctlDis  <= 1'b0;
      mrReset <= 1'b1;
    end else begin
      if (rateLoad) begin
        rateSel <= nibReg.rate.rateSel;
      end
      if (disLoad) begin
        crmDis <= nibReg.dis.crmDis;
        edpDis <= nibReg.dis.edpDis;
        ctlDis <= nibReg.dis.ctlDis;
      end
      // Set wins if both ever coincide
      if (setPulse) begin
        mrReset <= 1'b1;
      end else if (clrPulse) begin
        mrReset <= 1'b0;
      end
    end
  end

  // Read answer valid, held until taken
  always_ff @(posedge MBOX_CLK or posedge CLK) begin
    if (CLK) begin
      rdValid <= 1'b0;
    end else if (readPending) begin
      rdValid <= 1'b1;
    end else if (rdReady) begin
      rdValid <= 1'b0;
    end
  end

  // Status sampled one edge after the read is accepted
  always_ff @(posedge MBOX_CLK) begin
    if (readPending) begin
      rdData <= statusWord;
    end
  end

endmodule

`default_nettype wire

//--- rtl/burstCounter.sv
`timescale 1ns/100ps
`default_nettype none

module burstCounter import clkPkg::*; (
  input  logic              MBOX_CLK,
  input  logic              CLK,
  input  logic              loadLsb,
  input  logic              loadMsb,
  input  logic [nibW-1:0]   loadNibble,
  input  logic              decrement,
  output logic [burstW-1:0] burstCnt,
  output logic              burstZero
);

  // Low nibble, like the E21 counter
  always_ff @(posedge MBOX_CLK or posedge CLK) begin
    if (CLK) begin
      burstCnt <= '0;
    end else if (loadLsb) begin
      burstCnt[nibW-1:0] <= loadNibble;
    end else if (loadMsb) begin
      // High nibble, like E15
      burstCnt[burstW-1:nibW] <= loadNibble;
    end else if (decrement && !burstZero) begin
      // One count per qualified tick, never below zero
      burstCnt <= burstCnt - burstW'(1);
    end
  end

  // Ends the burst in eboxGate
  assign burstZero = (burstCnt == '0);

endmodule

`default_nettype wire

//--- rtl/eboxGate.sv
`timescale 1ns/100ps
`default_nettype none

module eboxGate import clkPkg::*; (
  input  logic       MBOX_CLK,
  input  logic       CLK,
  input  logic       startPulse,
  input  logic       stepPulse,
  input  logic       haltPulse,
  input  logic       burstPulse,
  input  logic [1:0] rateSel,
  input  logic       crmDis,
  input  logic       edpDis,
  input  logic       ctlDis,
  input  logic       mrReset,
  input  logic       burstZero,
  output logic       decrement,
  output logic       running,
  output logic       stepPending,
  output logic       burstActive,
  output logic       crmClkEn,
  output logic       edpClkEn,
  output logic       ctlClkEn
);

  logic [rateDivW-1:0] divCnt;
  logic                divWrap;
  logic                tickEn;

  // Free-running rate divider
  always_ff @(posedge MBOX_CLK or posedge CLK) begin
    if (CLK) begin
      divCnt <= '0;
    end else begin
      divCnt <= divCnt + rateDivW'(1);
    end
  end

  // Tick every 1, 2, 4 or 8 cycles
  always_comb begin
    case (rateSel)
      2'd0:    divWrap = 1'b1;
      2'd1:    divWrap = divCnt[0];
      2'd2:    divWrap = &divCnt[1:0];
      default: divWrap = &divCnt;
    endcase
  end

  // Qualified tick, never while master reset holds
  assign tickEn    = divWrap & ~mrReset &
                     (running | stepPending | (burstActive & ~burstZero));
  assign decrement = tickEn & burstActive & ~burstZero;

  // Run, step and burst state
  always_ff @(posedge MBOX_CLK or posedge CLK) begin
    if (CLK) begin
      running     <= 1'b0;
      stepPending <= 1'b0;
      burstActive <= 1'b0;
    end else if (mrReset) begin
      running     <= 1'b0;
      stepPending <= 1'b0;
      burstActive <= 1'b0;
    end else begin
      if (haltPulse) begin
        running <= 1'b0;
      end else if (startPulse) begin
        running <= 1'b1;
      end
      // A step is used up by the next qualified tick
      if (stepPulse) begin
        stepPending <= 1'b1;
      end else if (tickEn) begin
        stepPending <= 1'b0;
      end
      // Empty counter means no burst at all
      if (burstPulse && !burstZero) begin
        burstActive <= 1'b1;
      end else if (burstZero) begin
        burstActive <= 1'b0;
      end
    end
  end

  // Per-group enables, registered
  always_ff @(posedge MBOX_CLK or posedge CLK) begin
    if (CLK) begin
      crmClkEn <= 1'b0;
      edpClkEn <= 1'b0;
      ctlClkEn <= 1'b0;
    end else begin
      crmClkEn <= tickEn & ~crmDis;
      edpClkEn <= tickEn & ~edpDis;
      ctlClkEn <= tickEn & ~ctlDis;
    end
  end

endmodule

`default_nettype wire

//--- rtl/diagStatusMux.sv
`timescale 1ns/100ps
`default_nettype none

module diagStatusMux import clkPkg::*; (
  input  logic [selW-1:0]   readSel,
  input  logic              running,
  input  logic              burstActive,
  input  logic              mrReset,
  input  logic              burstZero,
  input  logic [burstW-1:0] burstCnt,
  input  logic [1:0]        rateSel,
  input  logic              crmDis,
  input  logic              edpDis,
  input  logic              ctlDis,
  input  logic              stepPending,
  output logic [statW-1:0]  statusWord
);

  // Bit 0 of each word maps to EBus bit 30
  always_comb begin
    case (readSel)
      3'd0: begin
        // Run state plus top of the burst count
        statusWord = {running,
                      burstActive,
                      mrReset,
                      burstZero,
                      burstCnt[burstW-1 -: 2]};
      end
      3'd1: begin
        // Rest of the burst count
        statusWord = burstCnt[statW-1:0];
      end
      3'd2: begin
        // Loaded configuration
        statusWord = {rateSel,
                      crmDis,
                      edpDis,
                      ctlDis,
                      stepPending};
      end
      default: begin
        statusWord = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- rtl/clkCtl.sv
`timescale 1ns/100ps
`default_nettype none

module clkCtl import clkPkg::*; (
  input  logic              MBOX_CLK,
  input  logic              CLK,
  input  logic              cmdValid,
  output logic              cmdReady,
  input  logic [cmdOpW-1:0] cmdOp,
  input  logic [selW-1:0]   cmdSel,
  input  logic [nibW-1:0]   cmdData,
  output logic              rdValid,
  input  logic              rdReady,
  output logic [statW-1:0]  rdData,
  output logic              crmClkEn,
  output logic              edpClkEn,
  output logic              ctlClkEn,
  output logic              mrReset
);

  // Strobes out of the decoder
  logic              startPulse;
  logic              stepPulse;
  logic              haltPulse;
  logic              burstPulse;
  logic              loadLsb;
  logic              loadMsb;
  logic [nibW-1:0]   loadNibble;
  // Configuration
  logic [selW-1:0]   readSel;
  logic [1:0]        rateSel;
  logic              crmDis;
  logic              edpDis;
  logic              ctlDis;
  // Counter and gate state
  logic [burstW-1:0] burstCnt;
  logic              burstZero;
  logic              decrement;
  logic              running;
  logic              stepPending;
  logic              burstActive;
  logic [statW-1:0]  statusWord;

  diagFuncDecode i_diagFuncDecode (
    .MBOX_CLK, .CLK, .cmdValid, .cmdReady, .cmdOp, .cmdSel, .cmdData,
    .rdValid, .rdReady, .rdData, .statusWord,
    .startPulse, .stepPulse, .haltPulse, .burstPulse, .loadLsb, .loadMsb,
    .loadNibble, .readSel, .rateSel, .crmDis, .edpDis, .ctlDis, .mrReset
  );

  burstCounter i_burstCounter (
    .MBOX_CLK, .CLK, .loadLsb, .loadMsb, .loadNibble, .decrement,
    .burstCnt, .burstZero
  );

  eboxGate i_eboxGate (
    .MBOX_CLK, .CLK, .startPulse, .stepPulse, .haltPulse, .burstPulse,
    .rateSel, .crmDis, .edpDis, .ctlDis, .mrReset, .burstZero,
    .decrement, .running, .stepPending, .burstActive,
    .crmClkEn, .edpClkEn, .ctlClkEn
  );

  // Read word goes back to the decoder for registering
  diagStatusMux i_diagStatusMux (
    .readSel, .running, .burstActive, .mrReset, .burstZero, .burstCnt,
    .rateSel, .crmDis, .edpDis, .ctlDis, .stepPending, .statusWord
  );

endmodule

`default_nettype wire

//--- test/clkCtlVectors.svh
`ifndef CLKCTLVECTORS_SVH
`define CLKCTLVECTORS_SVH

// Rows are a command with a wait, a read with its expected word,
// or a pulse window with CRM, EDP and CTL counts and a tolerance
task automatic fillTable();
  // No enables while master reset holds
  vecTab.push_back(pulseRow(16, 0, 0, 0, 0));
  vecTab.push_back(readRow(3'd0, statusRun(1'b0, 1'b0, 1'b1, 1'b1, 2'b00), 1'b0));
  // Burst of 0x25 on all groups
  vecTab.push_back(cmdRow(opCtl, fnClrReset, 4'h0, 2));
  vecTab.push_back(cmdRow(opLoad, ldBurstLsb, 4'h5, 0));
  vecTab.push_back(cmdRow(opLoad, ldBurstMsb, 4'h2, 0));
  vecTab.push_back(readRow(3'd1, 6'h25, 1'b0));
  vecTab.push_back(cmdRow(opCtl, fnBurst, 4'h0, 0));
  vecTab.push_back(pulseRow(50, 37, 37, 37, 0));
  vecTab.push_back(readRow(3'd1, 6'h00, 1'b0));
  vecTab.push_back(readRow(3'd0, statusRun(1'b0, 1'b0, 1'b0, 1'b1, 2'b00), 1'b0));
  // Free run over 32 cycles at rate 0 and then at rate 2
  vecTab.push_back(cmdRow(opCtl, fnStart, 4'h0, 32));
  vecTab.push_back(cmdRow(opCtl, fnHalt, 4'h0, 0));
  vecTab.push_back(pulseRow(4, 32, 32, 32, 1));
  vecTab.push_back(cmdRow(opLoad, ldRate, rateNib(2), 0));
  vecTab.push_back(cmdRow(opCtl, fnStart, 4'h0, 32));
  vecTab.push_back(cmdRow(opCtl, fnHalt, 4'h0, 0));
  vecTab.push_back(pulseRow(4, 8, 8, 8, 1));
  // Burst of 10 at rate 2 with CRM and CTL gated off
  vecTab.push_back(cmdRow(opLoad, ldGroupDis, disNib(1'b1, 1'b0, 1'b1), 0));
  vecTab.push_back(cmdRow(opLoad, ldBurstLsb, 4'hA, 0));
  vecTab.push_back(cmdRow(opLoad, ldBurstMsb, 4'h0, 0));
  vecTab.push_back(cmdRow(opCtl, fnBurst, 4'h0, 0));
  vecTab.push_back(pulseRow(60, 0, 10, 0, 0));
  vecTab.push_back(readRow(3'd2, statusCfg(2'd2, 1'b1, 1'b0, 1'b1, 1'b0), 1'b0));
  // Single steps give one pulse per group
  vecTab.push_back(cmdRow(opLoad, ldRate, rateNib(0), 0));
  vecTab.push_back(cmdRow(opLoad, ldGroupDis, disNib(1'b0, 1'b0, 1'b0), 0));
  vecTab.push_back(cmdRow(opCtl, fnSingleStep, 4'h0, 0));
  vecTab.push_back(pulseRow(6, 1, 1, 1, 0));
  vecTab.push_back(cmdRow(opCtl, fnSingleStep, 4'h0, 0));
  vecTab.push_back(pulseRow(6, 1, 1, 1, 0));
  // Short burst runs out while the read answer is stalled
  vecTab.push_back(cmdRow(opLoad, ldBurstLsb, 4'h3, 0));
  vecTab.push_back(cmdRow(opLoad, ldBurstMsb, 4'h0, 0));
  vecTab.push_back(cmdRow(opCtl, fnBurst, 4'h0, 0));
  vecTab.push_back(readRow(3'd0, statusRun(1'b0, 1'b1, 1'b0, 1'b0, 2'b00), 1'b1));
  vecTab.push_back(pulseRow(4, 3, 3, 3, 0));
  // No steps once master reset is back
  vecTab.push_back(cmdRow(opCtl, fnSetReset, 4'h0, 2));
  vecTab.push_back(cmdRow(opCtl, fnSingleStep, 4'h0, 0));
  vecTab.push_back(pulseRow(8, 0, 0, 0, 0));
  // Status under master reset and an unused select
  vecTab.push_back(readRow(3'd0, statusRun(1'b0, 1'b0, 1'b1, 1'b1, 2'b00), 1'b0));
  vecTab.push_back(readRow(3'd5, 6'h00, 1'b0));
endtask

`endif

//--- test/clkCtlTb.sv
`timescale 1ns/100ps
`default_nettype none

module clkCtlTb import clkPkg::*; ();

  // Row kinds
  localparam int actCmd   = 0;
  localparam int actRead  = 1;
  localparam int actStall = 2;
  localparam int actPulse = 3;

  typedef struct packed {
    int                act;
    logic [cmdOpW-1:0] op;
    logic [selW-1:0]   sel;
    logic [nibW-1:0]   data;
    int                waitCyc;
    logic [statW-1:0]  word;
    int                crm;
    int                edp;
    int                ctl;
    int                tol;
  } rowT;

  logic              MBOX_CLK = 1'b0;
  logic              CLK = 1'b1;
  logic              cmdValid;
  logic              cmdReady;
  logic [cmdOpW-1:0] cmdOp;
  logic [selW-1:0]   cmdSel;
  logic [nibW-1:0]   cmdData;
  logic              rdValid;
  logic              rdReady;
  logic [statW-1:0]  rdData;
  logic              crmClkEn;
  logic              edpClkEn;
  logic              ctlClkEn;
  logic              mrReset;

  // Pulse totals and the totals at the last window check
  int   crmCnt = 0;
  int   edpCnt = 0;
  int   ctlCnt = 0;
  int   crmBase = 0;
  int   edpBase = 0;
  int   ctlBase = 0;
  int   errCnt = 0;
  int   cycleCnt = 0;
  int   cycleLimit = 100;
  rowT  vecTab[$];

  always #2 MBOX_CLK = ~MBOX_CLK;

  clkCtl i_clkCtl (
    .MBOX_CLK, .CLK, .cmdValid, .cmdReady, .cmdOp, .cmdSel, .cmdData,
    .rdValid, .rdReady, .rdData, .crmClkEn, .edpClkEn, .ctlClkEn, .mrReset
  );

  // Enables are registered, so the falling edge sees them settled
  always @(negedge MBOX_CLK) begin
    if (crmClkEn) begin
      crmCnt <= crmCnt + 1;
    end
    if (edpClkEn) begin
      edpCnt <= edpCnt + 1;
    end
    if (ctlClkEn) begin
      ctlCnt <= ctlCnt + 1;
    end
  end

  // Run limit
  always @(posedge MBOX_CLK) begin
    cycleCnt <= cycleCnt + 1;
    if (cycleCnt >= cycleLimit) begin
      $display("Timeout after %0d cycles, the DUT stopped answering", cycleCnt);
      $display("TEST FAILED");
      $finish;
    end
  end

  function automatic rowT cmdRow(input logic [cmdOpW-1:0] op, input logic [selW-1:0] sel,
                                 input logic [nibW-1:0] data, input int waitCyc);
    rowT row;
    row         = '0;
    row.act     = actCmd;
    row.op      = op;
    row.sel     = sel;
    row.data    = data;
    row.waitCyc = waitCyc;
    return row;
  endfunction

  function automatic rowT readRow(input logic [selW-1:0] sel, input logic [statW-1:0] word,
                                  input logic stall);
    rowT row;
    row      = '0;
    row.act  = stall ? actStall : actRead;
    row.sel  = sel;
    row.word = word;
    return row;
  endfunction

  function automatic rowT pulseRow(input int waitCyc, input int crm, input int edp,
                                   input int ctl, input int tol);
    rowT row;
    row         = '0;
    row.act     = actPulse;
    row.waitCyc = waitCyc;
    row.crm     = crm;
    row.edp     = edp;
    row.ctl     = ctl;
    row.tol     = tol;
    return row;
  endfunction

  // Load data built through the nibble views
  function automatic logic [nibW-1:0] rateNib(input int r);
    loadNibbleT nib;
    nib.raw          = '0;
    nib.rate.rateSel = 2'(r);
    return nib.raw;
  endfunction

  function automatic logic [nibW-1:0] disNib(input logic crm, input logic edp, input logic ctl);
    loadNibbleT nib;
    nib.raw        = '0;
    nib.dis.crmDis = crm;
    nib.dis.edpDis = edp;
    nib.dis.ctlDis = ctl;
    return nib.raw;
  endfunction

  // Status words, bit 0 is EBus bit 30
  function automatic logic [statW-1:0] statusRun(input logic run, input logic burst,
                                                 input logic mr, input logic zero,
                                                 input logic [1:0] cntTop);
    return {run, burst, mr, zero, cntTop};
  endfunction

  function automatic logic [statW-1:0] statusCfg(input logic [1:0] rate, input logic crm,
                                                 input logic edp, input logic ctl,
                                                 input logic step);
    return {rate, crm, edp, ctl, step};
  endfunction

  `include "clkCtlVectors.svh"

  task automatic checkValue(input string name, input int got, input int expVal, input int tol);
    int diff;
    diff = got - expVal;
    if (diff < 0) begin
      diff = -diff;
    end
    if (diff > tol) begin
      errCnt++;
      $display("Fail %0t %s got %0d expected %0d", $time, name, got, expVal);
    end
  endtask

  // Starts and ends on a falling edge, transfer on the edge between
  task automatic sendCmd(input logic [cmdOpW-1:0] op, input logic [selW-1:0] sel,
                         input logic [nibW-1:0] data);
    while (!cmdReady) begin
      @(negedge MBOX_CLK);
    end
    cmdValid = 1'b1;
    cmdOp    = op;
    cmdSel   = sel;
    cmdData  = data;
    @(negedge MBOX_CLK);
    cmdValid = 1'b0;
  endtask

  task automatic readWord(input logic [selW-1:0] sel, input logic [statW-1:0] expWord,
                          input logic stall);
    logic [statW-1:0] held;
    rdReady = ~stall;
    sendCmd(opRead, sel, 4'h0);
    while (!rdValid) begin
      @(negedge MBOX_CLK);
    end
    held = rdData;
    if (stall) begin
      // Answer must hold and the command side must stay blocked
      repeat (5) begin
        @(negedge MBOX_CLK);
        checkValue("rdData", int'(rdData), int'(held), 0);
        checkValue("rdValid", int'(rdValid), 1, 0);
        checkValue("cmdReady", int'(cmdReady), 0, 0);
      end
      rdReady = 1'b1;
    end
    checkValue("rdData", int'(held), int'(expWord), 0);
    @(negedge MBOX_CLK);
    checkValue("rdValid", int'(rdValid), 0, 0);
    checkValue("cmdReady", int'(cmdReady), 1, 0);
  endtask

  task automatic applyRow(input rowT row);
    case (row.act)
      actCmd: begin
        sendCmd(row.op, row.sel, row.data);
      end
      actRead: begin
        readWord(row.sel, row.word, 1'b0);
      end
      actStall: begin
        readWord(row.sel, row.word, 1'b1);
      end
      default: begin
      end
    endcase
    repeat (row.waitCyc) begin
      @(negedge MBOX_CLK);
    end
    if (row.act == actPulse) begin
      checkValue("crmClkEn pulses", crmCnt - crmBase, row.crm, row.tol);
      checkValue("edpClkEn pulses", edpCnt - edpBase, row.edp, row.tol);
      checkValue("ctlClkEn pulses", ctlCnt - ctlBase, row.ctl, row.tol);
      crmBase = crmCnt;
      edpBase = edpCnt;
      ctlBase = ctlCnt;
    end
  endtask

  initial begin
    int waitSum;
    cmdValid = 1'b0;
    cmdOp    = '0;
    cmdSel   = '0;
    cmdData  = '0;
    rdReady  = 1'b1;
    fillTable();
    waitSum = 0;
    foreach (vecTab[i]) begin
      waitSum += vecTab[i].waitCyc;
    end
    cycleLimit = 2 * waitSum + 100;
    // Reset for 8 cycles, released on a falling edge
    repeat (8) begin
      @(negedge MBOX_CLK);
    end
    CLK = 1'b0;
    @(negedge MBOX_CLK);
    checkValue("cmdReady", int'(cmdReady), 1, 0);
    checkValue("rdValid", int'(rdValid), 0, 0);
    checkValue("mrReset", int'(mrReset), 1, 0);
    foreach (vecTab[i]) begin
      applyRow(vecTab[i]);
    end
    $display("Errors: %0d", errCnt);
    if (errCnt == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- files.f
+incdir+test
rtl/clkPkg.sv
rtl/diagFuncDecode.sv
rtl/burstCounter.sv
rtl/eboxGate.sv
rtl/diagStatusMux.sv
rtl/clkCtl.sv
test/clkCtlTb.sv

//--- run.sh
#!/bin/sh
# Build and run the clkCtl testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/100ps \
  --top-module clkCtlTb --Mdir obj_dir -f files.f

./obj_dir/VclkCtlTb > sim.log 2>&1
cat sim.log

if grep -q "TEST FAILED" sim.log; then
  exit 1
fi
exit 0
